// ==== Makefile ====
TOP = tb_trace_subsys
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+.
osd_pkg.sv
osd_fifo.sv
osd_ctm.sv
osd_ctm_mor1kx.sv
osd_debug_router.sv
osd_debug_arbiter.sv
osd_trace_subsys.sv
osd_trace_properties.sv
tb_trace_checker.sv
tb_trace_subsys.sv

// ==== osd_config.svh ====
`ifndef OSD_CONFIG_SVH
`define OSD_CONFIG_SVH

// Number of mor1kx cores traced by the subsystem
`define OSD_NUM_CORES 4

// Debug ID of the CTM of core 0, core i answers at base plus i
`define OSD_CTM_BASE_ID 16'h0010

// Destination ID that all event packets are sent to
`define OSD_HOST_ID 16'h0000

// Queue depths in entries
`define OSD_TRACE_FIFO_DEPTH 4
`define OSD_OUT_FIFO_DEPTH 2

// Packet type codes carried in bits 15:14 of the third flit
`define OSD_TYPE_WRITE 2'b01
`define OSD_TYPE_EVENT 2'b10

`endif

// ==== osd_ctm.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "osd_config.svh"

module osd_ctm #(
   parameter logic [15:0] MODULE_ID = 16'h0000
) (
   input  logic                clk,
   input  logic                rst,
   input  osd_pkg::dii_flit    debug_in,
   output logic                debug_in_ready,
   output osd_pkg::dii_flit    debug_out,
   input  logic                debug_out_ready,
   input  osd_pkg::ctm_trace_t trace
);

   import osd_pkg::*;

   localparam int DEPTH = `OSD_TRACE_FIFO_DEPTH;
   localparam int OCC_W = $clog2(DEPTH + 1);

   // Register interface state
   logic [1:0]       rx_cnt;
   logic             rx_write;
   logic             rx_xfer;
   logic             enable;

   // Sample path state
   logic [31:0]      ts;
   ctm_sample_t      sample;
   ctm_sample_t      q_head;
   logic             q_full;
   logic             q_empty;
   logic             push;
   logic             accept;
   logic             drop;
   logic [OCC_W-1:0] occ;

   // Overflow bookkeeping
   logic             ovf_pending;
   logic             ovf_tag;
   logic [OCC_W-1:0] ovf_skip;
   logic             ovf_bit;

   // Event packet serialiser
   logic [3:0]       tx_cnt;
   logic             tx_last;
   logic             tx_xfer;
   logic             pop;

   // Writes are consumed as they arrive so the CTM never stalls the router
   assign debug_in_ready = 1'b1;
   assign rx_xfer        = debug_in.valid && debug_in_ready;

   // Flit 2 carries the packet type and flit 3 the value with the enable in bit 0
   always_ff @(posedge clk) begin
      if (rst) begin
         rx_cnt   <= '0;
         rx_write <= 1'b0;
         enable   <= 1'b0;
      end else if (rx_xfer) begin
         if (debug_in.last) begin
            rx_cnt <= '0;
         end else if (rx_cnt != 2'd3) begin
            rx_cnt <= rx_cnt + 1'b1;
         end
         if (rx_cnt == 2'd2) begin
            rx_write <= (debug_in.data[15:14] == `OSD_TYPE_WRITE);
         end
         if (rx_cnt == 2'd3 && rx_write) begin
            enable <= debug_in.data[0];
         end
      end
   end

   // Free running cycle count, zero in the first cycle after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         ts <= '0;
      end else begin
         ts <= ts + 1'b1;
      end
   end

   assign push   = enable && trace.valid;
   assign accept = push && !q_full;
   assign drop   = push && q_full;

   assign sample = '{pc: trace.pc, npc: trace.npc, jal: trace.jal, jalr: trace.jalr,
                     timestamp: ts};

   osd_fifo #(
      .DEPTH     (DEPTH),
      .payload_t (ctm_sample_t)
   ) u_sample_q (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (accept),
      .wr_data (sample),
      .full    (q_full),
      .rd_en   (pop),
      .rd_data (q_head),
      .empty   (q_empty)
   );

   assign tx_last = (tx_cnt == 4'd8);
   assign tx_xfer = debug_out.valid && debug_out_ready;
   // The queue entry leaves only with the last flit so the head stays stable
   assign pop     = tx_xfer && tx_last;

   // A drop arms a pending flag that tags the next accepted sample. The tag
   // remembers how many entries are queued ahead of that sample and counts
   // them down as they leave. A second drop while a tag is still in flight
   // waits until that tag is consumed
   always_ff @(posedge clk) begin
      if (rst) begin
         occ         <= '0;
         ovf_pending <= 1'b0;
         ovf_tag     <= 1'b0;
         ovf_skip    <= '0;
      end else begin
         occ <= occ + OCC_W'(accept) - OCC_W'(pop);
         if (drop) begin
            ovf_pending <= 1'b1;
         end else if (accept && ovf_pending && !ovf_tag) begin
            ovf_pending <= 1'b0;
            ovf_tag     <= 1'b1;
            ovf_skip    <= occ - OCC_W'(pop);
         end
         if (pop && ovf_tag) begin
            if (ovf_skip == '0) begin
               ovf_tag <= 1'b0;
            end else begin
               ovf_skip <= ovf_skip - 1'b1;
            end
         end
      end
   end

   // The head of the queue is the tagged sample once nothing is left ahead of it
   assign ovf_bit = ovf_tag && (ovf_skip == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_cnt <= '0;
      end else if (tx_xfer) begin
         tx_cnt <= tx_last ? 4'd0 : tx_cnt + 1'b1;
      end
   end

   always_comb begin
      debug_out.valid = !q_empty;
      debug_out.last  = tx_last;
      case (tx_cnt)
         4'd0:    debug_out.data = `OSD_HOST_ID;
         4'd1:    debug_out.data = MODULE_ID;
         4'd2:    debug_out.data = {`OSD_TYPE_EVENT, 11'b0, ovf_bit, q_head.jal, q_head.jalr};
         4'd3:    debug_out.data = q_head.timestamp[15:0];
         4'd4:    debug_out.data = q_head.timestamp[31:16];
         4'd5:    debug_out.data = q_head.pc[15:0];
         4'd6:    debug_out.data = q_head.pc[31:16];
         4'd7:    debug_out.data = q_head.npc[15:0];
         4'd8:    debug_out.data = q_head.npc[31:16];
         default: debug_out.data = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== osd_ctm_mor1kx.sv ====
`timescale 1ns/100ps
`default_nettype none

module osd_ctm_mor1kx #(
   parameter logic [15:0] MODULE_ID = 16'h0000
) (
   input  logic                      clk,
   input  logic                      rst,
   input  osd_pkg::dii_flit          debug_in,
   output logic                      debug_in_ready,
   output osd_pkg::dii_flit          debug_out,
   input  logic                      debug_out_ready,
   input  osd_pkg::mor1kx_trace_exec trace_port
);

   import osd_pkg::*;

   ctm_trace_t trace;
   logic       jump;

   // The core reports a jump target only for jal and jr
   assign jump = trace_port.jal || trace_port.jr;

   assign trace.valid = trace_port.valid;
   assign trace.pc    = trace_port.pc;
   // Sequential flow otherwise continues at the next 32-bit instruction
   assign trace.npc   = jump ? trace_port.jbtarget : trace_port.pc + 32'd4;
   assign trace.jal   = trace_port.jal;
   assign trace.jalr  = trace_port.jr;

   osd_ctm #(
      .MODULE_ID (MODULE_ID)
   ) u_ctm (
      .clk             (clk),
      .rst             (rst),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .trace           (trace)
   );

endmodule

`default_nettype wire

// ==== osd_debug_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "osd_config.svh"

module osd_debug_arbiter #(
   parameter int NUM_PORTS = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  osd_pkg::dii_flit port_in [NUM_PORTS],
   output logic             port_in_ready [NUM_PORTS],
   output osd_pkg::dii_flit debug_out,
   input  logic             debug_out_ready
);

   import osd_pkg::*;

   localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

   logic [IDX_W-1:0] gnt_q;
   logic             locked_q;
   logic [IDX_W-1:0] pick;
   logic             any_valid;
   logic [IDX_W-1:0] cur_gnt;
   logic             have_gnt;
   logic             xfer;
   logic             out_full;
   logic             out_empty;
   dii_flit          out_head;

   // Search starts one past the last granted port and the nearest valid port wins
   always_comb begin : rr_search
      int j;
      pick      = gnt_q;
      any_valid = 1'b0;
      for (int k = NUM_PORTS; k >= 1; k--) begin
         j = (int'(gnt_q) + k) % NUM_PORTS;
         if (port_in[j].valid) begin
            pick      = IDX_W'(j);
            any_valid = 1'b1;
         end
      end
   end

   // Once a packet has started its port keeps the grant until the last flit
   assign cur_gnt  = locked_q ? gnt_q : pick;
   assign have_gnt = locked_q || any_valid;
   assign xfer     = have_gnt && port_in[cur_gnt].valid && !out_full;

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ready
      assign port_in_ready[i] = have_gnt && !out_full && (cur_gnt == IDX_W'(i));
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         gnt_q    <= '0;
         locked_q <= 1'b0;
      end else if (xfer) begin
         gnt_q    <= cur_gnt;
         locked_q <= !port_in[cur_gnt].last;
      end
   end

   // Output buffer decouples the host back-pressure from the grant logic
   osd_fifo #(
      .DEPTH     (`OSD_OUT_FIFO_DEPTH),
      .payload_t (dii_flit)
   ) u_out_buf (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (xfer),
      .wr_data (port_in[cur_gnt]),
      .full    (out_full),
      .rd_en   (debug_out_ready),
      .rd_data (out_head),
      .empty   (out_empty)
   );

   assign debug_out.valid = !out_empty;
   assign debug_out.last  = out_head.last;
   assign debug_out.data  = out_head.data;

endmodule

`default_nettype wire

// ==== osd_debug_router.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "osd_config.svh"

module osd_debug_router #(
   parameter int NUM_PORTS = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  osd_pkg::dii_flit debug_in,
   output logic             debug_in_ready,
   output osd_pkg::dii_flit port_out [NUM_PORTS],
   input  logic             port_out_ready [NUM_PORTS]
);

   import osd_pkg::*;

   localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

   dii_flit          out_q [NUM_PORTS];
   logic [15:0]      dst_off;
   logic             dst_ok;
   logic             in_pkt;
   logic             drop_q;
   logic [IDX_W-1:0] sel_q;
   logic [IDX_W-1:0] cur_sel;
   logic             cur_drop;
   logic             slot_free;
   logic             accept;

   // Only the first flit of a packet carries the destination
   assign dst_off = debug_in.data - `OSD_CTM_BASE_ID;
   assign dst_ok  = (dst_off < 16'(NUM_PORTS));

   // Inside a packet the decision of its first flit holds
   assign cur_sel  = in_pkt ? sel_q : dst_off[IDX_W-1:0];
   assign cur_drop = in_pkt ? drop_q : !dst_ok;

   // An output register can take a flit when it is empty or drains this cycle
   assign slot_free      = !out_q[cur_sel].valid || port_out_ready[cur_sel];
   // Dropped flits are swallowed at full rate
   assign debug_in_ready = cur_drop || slot_free;
   assign accept         = debug_in.valid && debug_in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         in_pkt <= 1'b0;
         drop_q <= 1'b0;
         sel_q  <= '0;
      end else if (accept) begin
         in_pkt <= !debug_in.last;
         if (!in_pkt) begin
            sel_q  <= dst_off[IDX_W-1:0];
            drop_q <= !dst_ok;
         end
      end
   end

   // One flit register per output gives the single cycle of latency
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (rst) begin
            out_q[i].valid <= 1'b0;
         end else if (accept && !cur_drop && cur_sel == IDX_W'(i)) begin
            out_q[i] <= debug_in;
         end else if (port_out_ready[i]) begin
            out_q[i].valid <= 1'b0;
         end
      end
   end

   assign port_out = out_q;

endmodule

`default_nettype wire

// ==== osd_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module osd_fifo #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic [15:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     wr_en,
   input  payload_t wr_data,
   output logic     full,
   input  logic     rd_en,
   output payload_t rd_data,
   output logic     empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   // Pointers wrap at DEPTH so that any depth works, not only powers of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // A write into a full buffer or a read from an empty one is ignored
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   assign full    = (count == CNT_W'(DEPTH));
   assign empty   = (count == '0);
   // The head entry is visible without a read request
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_rd) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // Simultaneous read and write leave the fill level unchanged
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== osd_pkg.sv ====
`default_nettype none

package osd_pkg;

   // One flit of the debug interconnect
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   // Trace port as the mor1kx core presents it, one executed instruction per valid cycle
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] jbtarget;
      logic        jal;
      logic        jr;
   } mor1kx_trace_exec;

   // Core independent trace sample that the CTM consumes
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] npc;
      logic        jal;
      logic        jalr;
   } ctm_trace_t;

   // Entry held in the CTM sample queue until it is packed into an event packet
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] npc;
      logic        jal;
      logic        jalr;
      logic [31:0] timestamp;
   } ctm_sample_t;

endpackage

`default_nettype wire

// ==== osd_trace_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module osd_trace_properties (
   input logic             clk,
   input logic             rst,
   input osd_pkg::dii_flit debug_out,
   input logic             debug_out_ready
);

   // A flit on offer keeps its valid bit and its content until the host takes it
   a_hold_until_ready: assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out_ready |=> debug_out.valid && $stable(debug_out))
      else $error("debug_out changed before the host accepted the flit");

   // Nothing is offered to the host straight out of reset
   a_idle_after_reset: assert property (@(posedge clk)
      rst |=> !debug_out.valid)
      else $error("debug_out valid in the cycle after reset");

   // The valid bit is always known, and a valid flit is fully known
   a_known_flit: assert property (@(posedge clk) disable iff (rst)
      !$isunknown(debug_out.valid) && (!debug_out.valid || !$isunknown(debug_out)))
      else $error("debug_out carries unknown bits");

endmodule

`default_nettype wire

// ==== osd_trace_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "osd_config.svh"

module osd_trace_subsys #(
   parameter int NUM_CORES = `OSD_NUM_CORES
) (
   input  logic                      clk,
   input  logic                      rst,
   input  osd_pkg::dii_flit          debug_in,
   output logic                      debug_in_ready,
   output osd_pkg::dii_flit          debug_out,
   input  logic                      debug_out_ready,
   input  osd_pkg::mor1kx_trace_exec trace_port [NUM_CORES]
);

   import osd_pkg::*;

   // Host to CTM streams after the router
   dii_flit rt_flit   [NUM_CORES];
   logic    rt_ready  [NUM_CORES];
   // CTM to host streams ahead of the arbiter
   dii_flit ctm_flit  [NUM_CORES];
   logic    ctm_ready [NUM_CORES];

   osd_debug_router #(
      .NUM_PORTS (NUM_CORES)
   ) u_router (
      .clk            (clk),
      .rst            (rst),
      .debug_in       (debug_in),
      .debug_in_ready (debug_in_ready),
      .port_out       (rt_flit),
      .port_out_ready (rt_ready)
   );

   // Each core gets its own adapter and CTM with consecutive debug IDs
   for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
      osd_ctm_mor1kx #(
         .MODULE_ID (16'(`OSD_CTM_BASE_ID + i))
      ) u_ctm_mor1kx (
         .clk             (clk),
         .rst             (rst),
         .debug_in        (rt_flit[i]),
         .debug_in_ready  (rt_ready[i]),
         .debug_out       (ctm_flit[i]),
         .debug_out_ready (ctm_ready[i]),
         .trace_port      (trace_port[i])
      );
   end

   osd_debug_arbiter #(
      .NUM_PORTS (NUM_CORES)
   ) u_arbiter (
      .clk             (clk),
      .rst             (rst),
      .port_in         (ctm_flit),
      .port_in_ready   (ctm_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready)
   );

endmodule

`default_nettype wire

// ==== tb_trace_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "osd_config.svh"

module tb_trace_checker #(
   parameter int NUM_CORES = `OSD_NUM_CORES
) (
   input  logic                      clk,
   input  logic                      rst,
   input  osd_pkg::dii_flit          debug_in,
   input  logic                      debug_in_ready,
   input  osd_pkg::dii_flit          debug_out,
   input  logic                      debug_out_ready,
   input  osd_pkg::mor1kx_trace_exec trace_port [NUM_CORES],
   output int                        errors,
   output int                        checked,
   output int                        outstanding
);

   import osd_pkg::*;

   // Nine flits of one event packet, flit 0 in the lowest slot
   typedef logic [8:0][15:0] pkt_t;

   logic [31:0] cycle;
   logic        enabled [NUM_CORES];
   logic        ovf_armed [NUM_CORES];
   // Samples accepted per core whose packet has not reached the host yet
   int          inflight [NUM_CORES];
   int          wr_idx;
   logic [15:0] wr_dst;
   logic [1:0]  wr_type;
   pkt_t        rx;
   int          rx_idx;
   // Expected packets of all cores in sample order, with the test that caused each
   pkt_t        exp_q [$];
   string       exp_test [$];
   string       cur_test = "reset";

   task automatic set_test(input string name);
      cur_test = name;
   endtask

   function automatic string field_name(input int k);
      case (k)
         0:       return "destination";
         1:       return "source";
         2:       return "type and flags";
         3:       return "timestamp low";
         4:       return "timestamp high";
         5:       return "pc low";
         6:       return "pc high";
         7:       return "npc low";
         default: return "npc high";
      endcase
   endfunction

   // Event packet layout as the host expects it
   function automatic pkt_t make_packet(input logic [15:0] src, input logic ovf,
                                        input logic jal, input logic jalr,
                                        input logic [31:0] ts, input logic [31:0] pc,
                                        input logic [31:0] npc);
      pkt_t p;
      p[0] = `OSD_HOST_ID;
      p[1] = src;
      p[2] = {`OSD_TYPE_EVENT, 11'b0, ovf, jal, jalr};
      p[3] = ts[15:0];
      p[4] = ts[31:16];
      p[5] = pc[15:0];
      p[6] = pc[31:16];
      p[7] = npc[15:0];
      p[8] = npc[31:16];
      return p;
   endfunction

   // Host writes switch the enable bit of the addressed core
   task automatic log_host_write();
      int core;
      if (debug_in.valid && debug_in_ready) begin
         if (wr_idx == 0) wr_dst = debug_in.data;
         if (wr_idx == 2) wr_type = debug_in.data[15:14];
         if (debug_in.last) begin
            core = int'(wr_dst) - int'(`OSD_CTM_BASE_ID);
            if (wr_idx == 3 && wr_type == `OSD_TYPE_WRITE && core >= 0 && core < NUM_CORES) begin
               enabled[core] = debug_in.data[0];
            end
            wr_idx = 0;
         end else begin
            wr_idx++;
         end
      end
   endtask

   task automatic capture_traces();
      logic [31:0] npc;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (trace_port[c].valid && enabled[c]) begin
            if (inflight[c] == `OSD_TRACE_FIFO_DEPTH) begin
               // Queue is full, so this sample is lost and the next one reports it
               ovf_armed[c] = 1'b1;
            end else begin
               npc = (trace_port[c].jal || trace_port[c].jr) ? trace_port[c].jbtarget
                                                               : trace_port[c].pc + 32'd4;
               exp_q.push_back(make_packet(16'(`OSD_CTM_BASE_ID + c), ovf_armed[c],
                                           trace_port[c].jal, trace_port[c].jr, cycle,
                                           trace_port[c].pc, npc));
               exp_test.push_back(cur_test);
               inflight[c]++;
               ovf_armed[c] = 1'b0;
            end
         end
      end
   endtask

   // Packets from different cores may arrive in any order, so match by source
   task automatic match_packet();
      int found;
      int core;
      found = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
         if (found < 0 && exp_q[i][1] == rx[1]) found = i;
      end
      if (found < 0) begin
         $display("unexpected event packet from source %h during test %0s", rx[1], cur_test);
         errors++;
      end else begin
         for (int k = 0; k < 9; k++) begin
            if (rx[k] !== exp_q[found][k]) begin
               $display("mismatch %0s %0s: expected %h actual %h", exp_test[found],
                        field_name(k), exp_q[found][k], rx[k]);
               errors++;
            end
         end
         core = int'(rx[1]) - int'(`OSD_CTM_BASE_ID);
         inflight[core]--;
         exp_q.delete(found);
         exp_test.delete(found);
         checked++;
      end
   endtask

   task automatic collect_event();
      if (debug_out.valid && debug_out_ready) begin
         if (rx_idx < 9) rx[rx_idx] = debug_out.data;
         // The last bit belongs on flit 8 and nowhere else
         if (debug_out.last != (rx_idx == 8)) begin
            $display("event packet framing broken during test %0s: last is %0b on flit %0d",
                     cur_test, debug_out.last, rx_idx);
            errors++;
         end
         if (debug_out.last) begin
            if (rx_idx == 8) match_packet();
            rx_idx = 0;
         end else if (rx_idx < 9) begin
            rx_idx++;
         end
      end
   endtask

   // Cycle count mirrors the CTM timestamp, 0 in the first cycle after reset
   always @(posedge clk) begin
      if (rst) begin
         cycle   = '0;
         wr_idx  = 0;
         rx_idx  = 0;
         errors  = 0;
         checked = 0;
         for (int c = 0; c < NUM_CORES; c++) begin
            enabled[c]   = 1'b0;
            ovf_armed[c] = 1'b0;
            inflight[c]  = 0;
         end
      end else begin
         log_host_write();
         capture_traces();
         collect_event();
         cycle = cycle + 32'd1;
      end
      outstanding = exp_q.size();
   end

endmodule

`default_nettype wire

// ==== tb_trace_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "osd_config.svh"

module tb_trace_subsys;

   import osd_pkg::*;

   localparam int NUM_CORES    = `OSD_NUM_CORES;
   localparam int NUM_TESTS    = 16;
   localparam int CLK_PERIOD   = 20;
   localparam int STALL_LIMIT  = 100;
   localparam int DRAIN_LIMIT  = 400;
   localparam int QUIET_CYCLES = 20;
   localparam int STALL_HOLD   = 10;

   // One row of the test table, either a host write or a burst of trace samples
   typedef struct packed {
      logic                 is_write;
      logic [15:0]          dst;
      logic                 wval;
      logic [NUM_CORES-1:0] cores;
      logic [31:0]          pc;
      logic [31:0]          jbtarget;
      logic                 jal;
      logic                 jr;
      logic [3:0]           reps;
      logic                 stall;
   } test_row_t;

   logic             clk;
   logic             rst;
   dii_flit          debug_in;
   logic             debug_in_ready;
   dii_flit          debug_out;
   logic             debug_out_ready;
   mor1kx_trace_exec trace_port [NUM_CORES];
   int               chk_errors;
   int               chk_checked;
   int               chk_outstanding;
   int               tb_errors;
   test_row_t        rows [NUM_TESTS];
   string            names [NUM_TESTS];
   int               n_rows;

   osd_trace_subsys #(
      .NUM_CORES (NUM_CORES)
   ) DUT (
      .clk             (clk),
      .rst             (rst),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .trace_port      (trace_port)
   );

   tb_trace_checker #(
      .NUM_CORES (NUM_CORES)
   ) u_checker (
      .clk             (clk),
      .rst             (rst),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .trace_port      (trace_port),
      .errors          (chk_errors),
      .checked         (chk_checked),
      .outstanding     (chk_outstanding)
   );

   bind osd_trace_subsys osd_trace_properties u_props (
      .clk             (clk),
      .rst             (rst),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic add_write_row(input string name, input logic [15:0] dst, input logic val);
      rows[n_rows] = '{is_write: 1'b1, dst: dst, wval: val, default: '0};
      names[n_rows] = name;
      n_rows++;
   endtask

   task automatic add_trace_row(input string name, input logic [NUM_CORES-1:0] cores,
                                input logic [31:0] pc, input logic [31:0] jbt,
                                input logic jal, input logic jr, input int reps,
                                input logic stall);
      rows[n_rows] = '{is_write: 1'b0, dst: 16'h0, wval: 1'b0, cores: cores, pc: pc,
                       jbtarget: jbt, jal: jal, jr: jr, reps: 4'(reps), stall: stall};
      names[n_rows] = name;
      n_rows++;
   endtask

   task automatic build_table();
      n_rows = 0;
      // name, cores, pc, jbtarget, jal, jr, repeats, host ready held low
      add_write_row("enable_core0", 16'h0010, 1'b1);
      add_write_row("enable_core1", 16'h0011, 1'b1);
      add_write_row("enable_core2", 16'h0012, 1'b1);
      add_trace_row("seq_core0", 4'b0001, 32'h0000_1000, 32'h0, 1'b0, 1'b0, 1, 1'b0);
      add_trace_row("seq_core1", 4'b0010, 32'h0000_2000, 32'h0, 1'b0, 1'b0, 1, 1'b0);
      add_trace_row("seq_core2", 4'b0100, 32'h0000_3000, 32'h0, 1'b0, 1'b0, 1, 1'b0);
      add_trace_row("jal_core1", 4'b0010, 32'h0000_2400, 32'h0000_4000, 1'b1, 1'b0, 2, 1'b0);
      add_trace_row("jr_core2", 4'b0100, 32'h0000_3400, 32'h0000_5000, 1'b0, 1'b1, 2, 1'b0);
      add_trace_row("idle_core3", 4'b1000, 32'h0000_6000, 32'h0, 1'b0, 1'b0, 3, 1'b0);
      // The low offset bits of this ID alias core 0, which a leaked write would switch off
      add_write_row("write_unknown_id", 16'h0040, 1'b0);
      add_write_row("enable_core3", 16'h0013, 1'b1);
      add_trace_row("seq_core3", 4'b1000, 32'h0000_6400, 32'h0, 1'b0, 1'b0, 1, 1'b0);
      add_trace_row("overflow_fill", 4'b0001, 32'h0000_7000, 32'h0, 1'b0, 1'b0, 7, 1'b1);
      add_trace_row("overflow_flag", 4'b0001, 32'h0000_7400, 32'h0, 1'b0, 1'b0, 1, 1'b0);
      add_trace_row("overflow_clear", 4'b0001, 32'h0000_7800, 32'h0, 1'b0, 1'b0, 1, 1'b0);
      add_trace_row("all_cores", 4'b1111, 32'h0000_8000, 32'h0000_9000, 1'b1, 1'b0, 3, 1'b0);
   endtask

   // Offers one flit and returns after the edge that takes it
   task automatic send_flit(input dii_flit f, output logic ok);
      int waited;
      debug_in <= f;
      waited = 0;
      @(negedge clk);
      while (!debug_in_ready && waited < STALL_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      ok = debug_in_ready;
      @(posedge clk);
   endtask

   task automatic send_write(input logic [15:0] dst, input logic val);
      dii_flit flits [4];
      logic    ok;
      flits[0] = '{valid: 1'b1, last: 1'b0, data: dst};
      flits[1] = '{valid: 1'b1, last: 1'b0, data: `OSD_HOST_ID};
      flits[2] = '{valid: 1'b1, last: 1'b0, data: {`OSD_TYPE_WRITE, 14'b0}};
      flits[3] = '{valid: 1'b1, last: 1'b1, data: {15'b0, val}};
      ok = 1'b1;
      for (int k = 0; k < 4 && ok; k++) begin
         send_flit(flits[k], ok);
      end
      debug_in <= '0;
      if (!ok) begin
         $display("host write to %h stalled, debug_in_ready stayed low", dst);
         tb_errors++;
      end
   endtask

   // Each selected core gets its own pc so packets of different cores differ
   task automatic apply_trace(input test_row_t row);
      int gap;
      if (row.stall) debug_out_ready <= 1'b0;
      for (int r = 0; r < int'(row.reps); r++) begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (row.cores[c]) begin
               trace_port[c] <= '{valid: 1'b1, pc: row.pc + 32'(c * 256 + r * 4),
                                  jbtarget: row.jbtarget, jal: row.jal, jr: row.jr};
            end
         end
         @(posedge clk);
         for (int c = 0; c < NUM_CORES; c++) begin
            trace_port[c] <= '0;
         end
         gap = int'($urandom % 4) + 1;
         repeat (gap) @(posedge clk);
      end
      if (row.stall) begin
         repeat (STALL_HOLD) @(posedge clk);
         debug_out_ready <= 1'b1;
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      @(negedge clk);
      while (chk_outstanding != 0 && waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (chk_outstanding != 0) begin
         $display("timeout: %0d expected event packets never reached the host",
                  chk_outstanding);
         tb_errors++;
      end
      @(posedge clk);
   endtask

   task automatic run_test(input int t);
      int errs_before;
      int errs;
      // The checker updates its counts on the rising edge, so they are read on the falling one
      @(negedge clk);
      errs_before = chk_errors + tb_errors;
      u_checker.set_test(names[t]);
      @(posedge clk);
      if (rows[t].is_write) begin
         send_write(rows[t].dst, rows[t].wval);
      end else begin
         apply_trace(rows[t]);
      end
      wait_drain();
      // Quiet window in which a stray packet would still show up
      repeat (QUIET_CYCLES) @(posedge clk);
      @(negedge clk);
      errs = chk_errors + tb_errors - errs_before;
      $display("test %0d %0s: %0s, %0d errors", t, names[t], (errs == 0) ? "ok" : "FAILED", errs);
   endtask

   initial begin : main
      int total;
      void'($urandom(32'h1a84_97ea));
      clk             = 1'b0;
      rst             = 1'b1;
      debug_in        = '0;
      debug_out_ready = 1'b1;
      tb_errors       = 0;
      for (int c = 0; c < NUM_CORES; c++) begin
         trace_port[c] = '0;
      end
      build_table();
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      repeat (2) @(posedge clk);
      for (int t = 0; t < n_rows; t++) begin
         run_test(t);
      end
      total = chk_errors + tb_errors;
      $display("tests %0d, event packets checked %0d, errors %0d", n_rows, chk_checked, total);
      if (total == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Budget of 200 cycles per table row
   initial begin : watchdog
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("watchdog expired after %0d ns, the run did not complete",
               NUM_TESTS * 200 * CLK_PERIOD);
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire
